/* exc_params.svh */
/*
 * Exception entry constants
 * Vector numbers, frame format codes, SR bit positions, stack step
 */
`ifndef EXC_PARAMS_SVH
`define EXC_PARAMS_SVH

// Fixed vector numbers
`define EXC_VEC_ILLEGAL    8'd4
`define EXC_VEC_DIVZERO    8'd5
`define EXC_VEC_CHK        8'd6
`define EXC_VEC_PRIV       8'd8
`define EXC_VEC_TRACE      8'd9
`define EXC_VEC_AUTO_BASE  8'd24   // Plus interrupt level
`define EXC_VEC_TRAP_BASE  8'd32   // Plus TRAP operand

// Frame format codes
`define EXC_FMT_FOUR       4'h0    // Four-word frame
`define EXC_FMT_SIX        4'h2    // Six-word frame

`define EXC_SR_T_BIT       15
`define EXC_SR_S_BIT       13
`define EXC_SR_MASK_LO     8       // Interrupt mask is SR[10:8]

`define EXC_LONG_BYTES     4

`endif

/* exc_pkg.sv */
/*
 * Shared types of the exception entry unit
 * Width typedefs, kind and state enums, request/bus/context structs
 */
package exc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] sr_t;
    typedef logic [7:0]  vec_num_t;
    typedef logic [2:0]  irq_level_t;
    typedef logic [3:0]  trap_num_t;
    typedef logic [3:0]  fmt_t;

    // Listed in priority order after NONE
    typedef enum logic [2:0] {
        NONE, CHK, DIVZERO, TRAP, ILLEGAL, PRIV, TRACE, INT
    } exc_kind_t;

    typedef enum logic [1:0] {
        IDLE, STACK, FETCH, LOAD
    } exc_state_t;

    // One-cycle trap pulses from the core
    typedef struct packed {
        logic      chk;
        logic      divzero;
        logic      trap;
        trap_num_t trap_num;
        logic      illegal;
        logic      priv;
        logic      trace;
    } exc_trap_req_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } exc_bus_req_t;

    typedef struct packed {
        addr_t pc;
        addr_t sp;
        sr_t   sr;
    } exc_ctx_t;

endpackage

/* exc_pending.sv */
/*
 * Pending exception flags
 * Interrupt masking against SR and fixed priority resolution
 */
`timescale 1ns/1ps
`include "exc_params.svh"

module exc_pending (
    input  logic                   CLK,
    input  logic                   DATA_RDY,
    input  exc_pkg::exc_trap_req_t trap_in,
    input  exc_pkg::irq_level_t    irq_level,
    input  exc_pkg::sr_t           sr_in,
    input  logic                   take,
    output exc_pkg::exc_kind_t     pend_kind,
    output exc_pkg::trap_num_t     pend_trap_num,
    output exc_pkg::irq_level_t    pend_level
);
    import exc_pkg::*;

    logic [7:1] flag_q;         // Indexed by exc_kind_t
    logic [7:1] set_vec;
    logic [7:1] clr_vec;
    trap_num_t  trap_num_q;
    irq_level_t level_q;
    irq_level_t sr_mask;
    logic       int_accept;

    // --------------------
    // Interrupt masking
    assign sr_mask    = sr_in[`EXC_SR_MASK_LO +: 3];
    assign int_accept = (irq_level > sr_mask) || (irq_level == 3'd7); // Level 7 always in

    always_comb begin
        set_vec          = '0;
        set_vec[CHK]     = trap_in.chk;
        set_vec[DIVZERO] = trap_in.divzero;
        set_vec[TRAP]    = trap_in.trap;
        set_vec[ILLEGAL] = trap_in.illegal;
        set_vec[PRIV]    = trap_in.priv;
        set_vec[TRACE]   = trap_in.trace;
        set_vec[INT]     = int_accept;
    end

    // Only the kind being served is cleared
    always_comb begin
        clr_vec = '0;
        if (take && pend_kind != NONE)
            clr_vec[pend_kind] = 1'b1;
    end

    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            flag_q <= '0;
        end else begin
            flag_q <= (flag_q & ~clr_vec) | set_vec; // New request wins over clear
        end
    end

    always_ff @(posedge CLK) begin
        if (trap_in.trap)
            trap_num_q <= trap_in.trap_num;
        if (int_accept)
            level_q <= irq_level;
    end

    // --------------------
    // Priority encoder, lowest index wins
    always_comb begin
        pend_kind = NONE;
        for (int i = 7; i >= 1; i--) begin
            if (flag_q[i])
                pend_kind = exc_kind_t'(3'(i));
        end
    end

    assign pend_trap_num = trap_num_q;
    assign pend_level    = level_q;

endmodule

/* exc_vector.sv */
/*
 * Vector base register and vector number mapping
 * Registers table address, frame format and format/vector word on take
 */
`timescale 1ns/1ps
`include "exc_params.svh"

module exc_vector (
    input  logic                CLK,
    input  logic                DATA_RDY,
    input  logic                vbr_wr,
    input  exc_pkg::data_t      vbr_data,
    input  logic                take,
    input  exc_pkg::exc_kind_t  pend_kind,
    input  exc_pkg::trap_num_t  pend_trap_num,
    input  exc_pkg::irq_level_t pend_level,
    output exc_pkg::addr_t      vec_addr,
    output logic [15:0]         fv_word,
    output exc_pkg::fmt_t       fmt
);
    import exc_pkg::*;

    addr_t    vbr_q;
    vec_num_t vec_num;
    fmt_t     fmt_next;

    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY)
            vbr_q <= '0;
        else if (vbr_wr)
            vbr_q <= vbr_data;
    end

    // Kind to vector number and frame format
    always_comb begin
        fmt_next = `EXC_FMT_FOUR;
        case (pend_kind)
            CHK:     begin vec_num = `EXC_VEC_CHK;     fmt_next = `EXC_FMT_SIX; end
            DIVZERO: begin vec_num = `EXC_VEC_DIVZERO; fmt_next = `EXC_FMT_SIX; end
            TRACE:   begin vec_num = `EXC_VEC_TRACE;   fmt_next = `EXC_FMT_SIX; end
            TRAP:    vec_num = `EXC_VEC_TRAP_BASE + vec_num_t'(pend_trap_num);
            ILLEGAL: vec_num = `EXC_VEC_ILLEGAL;
            PRIV:    vec_num = `EXC_VEC_PRIV;
            INT:     vec_num = `EXC_VEC_AUTO_BASE + vec_num_t'(pend_level); // Autovector
            default: vec_num = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            vec_addr <= vbr_q + addr_t'(vec_num) * `EXC_LONG_BYTES;
            fmt      <= fmt_next;
            fv_word  <= {fmt_next, 2'b00, vec_num, 2'b00}; // Vector offset in [11:0]
        end
    end

endmodule

/* exc_sequencer.sv */
/*
 * Exception entry FSM
 * Context snapshot, stack frame writes, vector fetch and context load
 */
`timescale 1ns/1ps
`include "exc_params.svh"

module exc_sequencer (
    input  logic                   CLK,
    input  logic                   DATA_RDY,
    input  logic                   cpu_busy,
    input  exc_pkg::exc_kind_t     pend_kind,
    input  exc_pkg::irq_level_t    pend_level,
    input  exc_pkg::sr_t           sr_in,
    input  exc_pkg::addr_t         pc_in,
    input  exc_pkg::addr_t         adr_in,
    input  exc_pkg::addr_t         sp_in,
    input  exc_pkg::addr_t         vec_addr,
    input  logic [15:0]            fv_word,
    input  exc_pkg::fmt_t          fmt,
    output logic                   take,
    output exc_pkg::exc_bus_req_t  bus_req,
    input  logic                   bus_ready,
    input  exc_pkg::data_t         bus_rdata,
    output exc_pkg::exc_ctx_t      ctx_out,
    output logic                   ctx_load,
    output logic                   busy_exh
);
    import exc_pkg::*;

    exc_state_t state_q;
    logic [1:0] cnt_q;          // Longs already stacked
    logic [1:0] n_longs;
    logic       last_long;
    exc_kind_t  kind_q;
    irq_level_t level_q;
    sr_t        sr_q;
    addr_t      pc_q;
    addr_t      adr_q;
    addr_t      sp_q;
    addr_t      pc_new_q;       // Handler address from the vector table
    addr_t      stack_addr;
    sr_t        sr_new;

    assign take      = (state_q == IDLE) && (pend_kind != NONE) && !cpu_busy;
    assign n_longs   = (fmt == `EXC_FMT_SIX) ? 2'd3 : 2'd2;
    assign last_long = (cnt_q == n_longs - 2'd1);

    // Frame grows downward one long per write
    assign stack_addr = sp_q - (addr_t'(cnt_q) + 32'd1) * `EXC_LONG_BYTES;

    // --------------------
    // State register
    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (take)
                        state_q <= STACK;
                end
                STACK: begin
                    if (bus_ready) begin
                        cnt_q <= cnt_q + 2'd1;
                        if (last_long)
                            state_q <= FETCH;
                    end
                end
                FETCH: if (bus_ready) state_q <= LOAD;
                LOAD:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Snapshot on entry, handler PC on read completion
    always_ff @(posedge CLK) begin
        if (take) begin
            kind_q  <= pend_kind;
            level_q <= pend_level;
            sr_q    <= sr_in;
            pc_q    <= pc_in;
            adr_q   <= adr_in;
            sp_q    <= sp_in;
        end
        if (state_q == FETCH && bus_ready)
            pc_new_q <= bus_rdata;
    end

    // --------------------
    // Bus request, held by registered state during stalls
    always_comb begin
        bus_req = '0;
        case (state_q)
            STACK: begin
                bus_req.valid = 1'b1;
                bus_req.write = 1'b1;
                bus_req.addr  = stack_addr;
                if (fmt == `EXC_FMT_SIX && cnt_q == 2'd0)
                    bus_req.wdata = adr_q;              // Format 2 fault address
                else if (last_long)
                    bus_req.wdata = {sr_q, fv_word};
                else
                    bus_req.wdata = pc_q;
            end
            FETCH: begin
                bus_req.valid = 1'b1;
                bus_req.addr  = vec_addr;
            end
            default: ;
        endcase
    end

    always_comb begin
        sr_new                = sr_q;
        sr_new[`EXC_SR_S_BIT] = 1'b1;   // Supervisor
        sr_new[`EXC_SR_T_BIT] = 1'b0;   // No trace in handler
        if (kind_q == INT)
            sr_new[`EXC_SR_MASK_LO +: 3] = level_q;
    end

    assign ctx_out.pc = pc_new_q;
    assign ctx_out.sp = sp_q - addr_t'(cnt_q) * `EXC_LONG_BYTES;
    assign ctx_out.sr = sr_new;
    assign ctx_load   = (state_q == LOAD);
    assign busy_exh   = (state_q != IDLE);

endmodule

/* exc_handler_top.sv */
/*
 * Exception entry unit top level
 * Pending flags, vector unit and entry sequencer
 */
`timescale 1ns/1ps

module exc_handler_top (
    input  logic                   CLK,
    input  logic                   DATA_RDY,
    input  logic                   cpu_busy,
    input  exc_pkg::exc_trap_req_t trap_in,
    input  exc_pkg::irq_level_t    irq_level,
    input  exc_pkg::sr_t           sr_in,
    input  exc_pkg::addr_t         pc_in,
    input  exc_pkg::addr_t         adr_in,
    input  exc_pkg::addr_t         sp_in,
    input  logic                   vbr_wr,
    input  exc_pkg::data_t         vbr_data,
    output exc_pkg::exc_bus_req_t  bus_req,
    input  logic                   bus_ready,
    input  exc_pkg::data_t         bus_rdata,
    output exc_pkg::exc_ctx_t      ctx_out,
    output logic                   ctx_load,
    output logic                   busy_exh
);
    import exc_pkg::*;

    exc_kind_t   pend_kind;
    trap_num_t   pend_trap_num;
    irq_level_t  pend_level;
    logic        take;
    addr_t       vec_addr;
    logic [15:0] fv_word;
    fmt_t        fmt;

    exc_pending u_pending (
        .CLK(CLK), .DATA_RDY(DATA_RDY),
        .trap_in(trap_in), .irq_level(irq_level), .sr_in(sr_in), .take(take),
        .pend_kind(pend_kind), .pend_trap_num(pend_trap_num), .pend_level(pend_level)
    );

    exc_vector u_vector (
        .CLK(CLK), .DATA_RDY(DATA_RDY),
        .vbr_wr(vbr_wr), .vbr_data(vbr_data), .take(take),
        .pend_kind(pend_kind), .pend_trap_num(pend_trap_num), .pend_level(pend_level),
        .vec_addr(vec_addr), .fv_word(fv_word), .fmt(fmt)
    );

    exc_sequencer u_sequencer (
        .CLK(CLK), .DATA_RDY(DATA_RDY), .cpu_busy(cpu_busy),
        .pend_kind(pend_kind), .pend_level(pend_level),
        .sr_in(sr_in), .pc_in(pc_in), .adr_in(adr_in), .sp_in(sp_in),
        .vec_addr(vec_addr), .fv_word(fv_word), .fmt(fmt), .take(take),
        .bus_req(bus_req), .bus_ready(bus_ready), .bus_rdata(bus_rdata),
        .ctx_out(ctx_out), .ctx_load(ctx_load), .busy_exh(busy_exh)
    );

endmodule

/* exc_assertions.sv */
/*
 * Bus handshake, context strobe and reset assertions
 */
`timescale 1ns/1ps

module exc_assertions (
    input logic                  CLK,
    input logic                  DATA_RDY,
    input exc_pkg::exc_bus_req_t bus_req,
    input logic                  bus_ready,
    input logic                  ctx_load,
    input logic                  busy_exh
);
    int stall_errs = 0;
    int load_errs  = 0;
    int reset_errs = 0;

    stall_stable: assert property (@(posedge CLK) disable iff (DATA_RDY)
        bus_req.valid && !bus_ready |=> $stable(bus_req))
        else begin $error("bus request changed during a stall"); stall_errs++; end

    load_single: assert property (@(posedge CLK) disable iff (DATA_RDY)
        ctx_load |=> !ctx_load)
        else begin $error("ctx_load held for more than one cycle"); load_errs++; end

    // Outputs idle while reset is held
    reset_idle: assert property (@(posedge CLK)
        DATA_RDY |-> !busy_exh && !bus_req.valid && !ctx_load)
        else begin $error("outputs active during reset"); reset_errs++; end

endmodule

/* exc_checker.sv */
/*
 * Bus and context monitor for the exception entry unit
 * Rebuilds frame, fetch address and context from the expected row
 */
`timescale 1ns/1ps
`include "exc_params.svh"

module exc_checker (
    input  logic                  CLK,
    input  logic                  DATA_RDY,
    input  logic                  cpu_busy,
    input  exc_pkg::exc_bus_req_t bus_req,
    input  logic                  bus_ready,
    input  exc_pkg::exc_ctx_t     ctx_out,
    input  logic                  ctx_load,
    input  logic                  busy_exh,
    input  logic                  exp_entry,
    input  logic                  exp_int,
    input  logic                  row_done,
    input  exc_pkg::vec_num_t     exp_vec,
    input  exc_pkg::fmt_t         exp_fmt,
    input  exc_pkg::sr_t          exp_sr,
    input  exc_pkg::addr_t        exp_pc,
    input  exc_pkg::addr_t        exp_adr,
    input  exc_pkg::addr_t        exp_sp,
    input  exc_pkg::addr_t        exp_vbr,
    output int                    err_count,
    output int                    test_count
);
    import exc_pkg::*;

    int   n_wr;
    int   n_rd;
    int   row_errs;
    logic saw_busy;
    logic busy_d;
    logic cpu_busy_d;

    function automatic int n_longs();
        return (exp_fmt == `EXC_FMT_SIX) ? 3 : 2;
    endfunction

    function automatic addr_t fetch_addr();
        return exp_vbr + {22'd0, exp_vec, 2'b00};
    endfunction

    // Long word i of the frame counted from the top of the stack
    function automatic data_t frame_word(input int i);
        logic [15:0] fv;
        fv = {exp_fmt, 12'(exp_vec) * 12'd4};
        if (exp_fmt == `EXC_FMT_SIX && i == 0)
            return exp_adr;
        if ((exp_fmt == `EXC_FMT_SIX && i == 1) || (exp_fmt != `EXC_FMT_SIX && i == 0))
            return exp_pc;
        return {exp_sr, fv};
    endfunction

    function automatic sr_t handler_sr();
        sr_t s;
        s                = exp_sr;
        s[`EXC_SR_S_BIT] = 1'b1;
        s[`EXC_SR_T_BIT] = 1'b0;
        if (exp_int)
            s[`EXC_SR_MASK_LO +: 3] = 3'(exp_vec - `EXC_VEC_AUTO_BASE);
        return s;
    endfunction

    task automatic compare(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
            row_errs++;
        end
    endtask

    task automatic flag_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        err_count++;
        row_errs++;
    endtask

    task automatic finish_test();
        if (row_errs == 0)
            $display("Entry %0d: pass", test_count);
        else
            $display("Entry %0d: %0d errors", test_count, row_errs);
        test_count++;
        row_errs = 0;
        n_wr     = 0;
        n_rd     = 0;
        saw_busy = 1'b0;
    endtask

    // --------------------
    // Sampled mid-cycle where inputs and bus are stable
    always @(negedge CLK) begin
        if (DATA_RDY) begin
            err_count  = 0;
            test_count = 0;
            row_errs   = 0;
            n_wr       = 0;
            n_rd       = 0;
            saw_busy   = 1'b0;
        end else begin
            if (busy_exh)
                saw_busy = 1'b1;
            if (busy_exh && !busy_d && cpu_busy_d)
                flag_error("an exception was taken while the core was busy");
            if (bus_req.valid && bus_ready) begin
                if (!bus_req.write) begin
                    compare("fetch address", bus_req.addr, fetch_addr());
                    n_rd++;
                end else if (n_wr >= n_longs()) begin
                    flag_error("the frame has more stack writes than its format allows");
                end else begin
                    compare("stack address", bus_req.addr,
                            exp_sp - 32'((n_wr + 1) * `EXC_LONG_BYTES));
                    compare("stack data", bus_req.wdata, frame_word(n_wr));
                    n_wr++;
                end
            end
            if (ctx_load) begin
                if (!exp_entry)
                    flag_error("an exception entry happened where none was expected");
                if (!busy_exh)
                    flag_error("busy_exh was low during the context load");
                if (n_wr != n_longs())
                    flag_error("a stack write is missing");
                if (n_rd != 1)
                    flag_error("the vector fetch is missing");
                compare("new pc", ctx_out.pc, fetch_addr() ^ 32'h5A5A_0000);
                compare("new sp", ctx_out.sp, exp_sp - 32'(n_longs() * `EXC_LONG_BYTES));
                compare("new sr", {16'd0, ctx_out.sr}, {16'd0, handler_sr()});
                finish_test();
            end
            if (row_done && !exp_entry) begin
                if (saw_busy || n_wr != 0 || n_rd != 0)
                    flag_error("a masked interrupt started an exception entry");
                finish_test();
            end
        end
        busy_d     = busy_exh;
        cpu_busy_d = cpu_busy;
    end

endmodule

/* tb_exc_handler.sv */
/*
 * Testbench for the exception entry unit
 * Clock, reset, stimulus table, memory responder, watchdog and DUT
 */
`timescale 1ns/1ps
`include "exc_params.svh"

module tb_exc_handler;
    import exc_pkg::*;

    localparam int  NUM_ROWS    = 12;
    localparam time WATCHDOG_NS = NUM_ROWS * 200 * 40;

    typedef struct {
        exc_trap_req_t trap;
        irq_level_t    irq;
        sr_t           sr;
        addr_t         sp;
        addr_t         pc;
        addr_t         adr;
        logic          vbr_we;
        data_t         vbr;
        logic          entry;       // Row expects one exception entry
        logic          is_int;
        vec_num_t      vec;
        fmt_t          fmt;
    } row_t;

    row_t rows [NUM_ROWS];

    logic          CLK;
    logic          DATA_RDY;
    logic          cpu_busy;
    exc_trap_req_t trap_in;
    irq_level_t    irq_level;
    sr_t           sr_in;
    addr_t         pc_in;
    addr_t         adr_in;
    addr_t         sp_in;
    logic          vbr_wr;
    data_t         vbr_data;
    exc_bus_req_t  bus_req;
    logic          bus_ready;
    data_t         bus_rdata;
    exc_ctx_t      ctx_out;
    logic          ctx_load;
    logic          busy_exh;

    // Expected values for the checker
    logic          exp_entry;
    logic          exp_int;
    logic          row_done;
    vec_num_t      exp_vec;
    fmt_t          exp_fmt;
    sr_t           exp_sr;
    addr_t         exp_pc;
    addr_t         exp_adr;
    addr_t         exp_sp;
    addr_t         exp_vbr;
    int            err_count;
    int            test_count;
    int            asrt_errs;
    int            stall;

    exc_handler_top UUT (
        .CLK(CLK), .DATA_RDY(DATA_RDY), .cpu_busy(cpu_busy),
        .trap_in(trap_in), .irq_level(irq_level), .sr_in(sr_in),
        .pc_in(pc_in), .adr_in(adr_in), .sp_in(sp_in),
        .vbr_wr(vbr_wr), .vbr_data(vbr_data),
        .bus_req(bus_req), .bus_ready(bus_ready), .bus_rdata(bus_rdata),
        .ctx_out(ctx_out), .ctx_load(ctx_load), .busy_exh(busy_exh)
    );

    bind exc_handler_top exc_assertions u_asrt (
        .CLK(CLK), .DATA_RDY(DATA_RDY), .bus_req(bus_req),
        .bus_ready(bus_ready), .ctx_load(ctx_load), .busy_exh(busy_exh)
    );

    exc_checker u_checker (
        .CLK(CLK), .DATA_RDY(DATA_RDY), .cpu_busy(cpu_busy),
        .bus_req(bus_req), .bus_ready(bus_ready),
        .ctx_out(ctx_out), .ctx_load(ctx_load), .busy_exh(busy_exh),
        .exp_entry(exp_entry), .exp_int(exp_int), .row_done(row_done),
        .exp_vec(exp_vec), .exp_fmt(exp_fmt), .exp_sr(exp_sr),
        .exp_pc(exp_pc), .exp_adr(exp_adr), .exp_sp(exp_sp), .exp_vbr(exp_vbr),
        .err_count(err_count), .test_count(test_count)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // --------------------
    // Memory responder with 0 to 3 wait cycles per transfer
    initial begin
        bus_ready = 1'b0;
        bus_rdata = '0;
        stall     = -1;
        forever begin
            @(posedge CLK);
            #1;
            bus_ready = 1'b0;
            if (bus_req.valid) begin
                if (stall < 0)
                    stall = $urandom % 4;
                if (stall == 0) begin
                    bus_ready = 1'b1;
                    bus_rdata = bus_req.addr ^ 32'h5A5A_0000;
                    stall     = -1;
                end else begin
                    stall--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the exception entries did not finish in time");
        $display("Test failed");
        $finish;
    end

    // pulses = {chk, divzero, trap, illegal, priv, trace}
    task automatic set_row(input int i, input logic [5:0] pulses, input trap_num_t tn,
                           input irq_level_t irq, input sr_t sr, input vec_num_t vec,
                           input fmt_t fmt, input logic is_int, input logic entry);
        rows[i].trap   = {pulses[5:3], tn, pulses[2:0]};
        rows[i].irq    = irq;
        rows[i].sr     = sr;
        rows[i].sp     = 32'h0000_4000 + 32'(i) * 32'h40;
        rows[i].pc     = 32'h0010_0000 + 32'(i) * 32'h6;
        rows[i].adr    = 32'hA000_0000 | 32'(i);
        rows[i].vbr_we = 1'b0;
        rows[i].vbr    = '0;
        rows[i].entry  = entry;
        rows[i].is_int = is_int;
        rows[i].vec    = vec;
        rows[i].fmt    = fmt;
    endtask

    // Starts and ends just after a rising edge
    task automatic apply_row(input int i);
        cpu_busy  = 1'b1;
        sr_in     = rows[i].sr;
        pc_in     = rows[i].pc;
        adr_in    = rows[i].adr;
        sp_in     = rows[i].sp;
        exp_entry = rows[i].entry;
        exp_int   = rows[i].is_int;
        exp_vec   = rows[i].vec;
        exp_fmt   = rows[i].fmt;
        exp_sr    = rows[i].sr;
        exp_pc    = rows[i].pc;
        exp_adr   = rows[i].adr;
        exp_sp    = rows[i].sp;
        if (rows[i].vbr_we)
            exp_vbr = rows[i].vbr;
        trap_in   = rows[i].trap;
        irq_level = rows[i].irq;
        vbr_wr    = rows[i].vbr_we;
        vbr_data  = rows[i].vbr;
        @(posedge CLK);
        #1;
        trap_in   = '0;
        irq_level = '0;
        vbr_wr    = 1'b0;
        repeat (3) @(posedge CLK);     // Flags pending while the core is busy
        #1 cpu_busy = 1'b0;
        if (rows[i].entry) begin
            do @(negedge CLK); while (ctx_load !== 1'b1);
            @(posedge CLK);
            #1;
        end else begin
            repeat (6) @(posedge CLK);
            #1 row_done = 1'b1;
            @(posedge CLK);
            #1 row_done = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h311091cf));
        DATA_RDY  = 1'b0;
        cpu_busy  = 1'b1;
        trap_in   = '0;
        irq_level = '0;
        sr_in     = '0;
        pc_in     = '0;
        adr_in    = '0;
        sp_in     = '0;
        vbr_wr    = 1'b0;
        vbr_data  = '0;
        row_done  = 1'b0;
        exp_entry = 1'b0;
        exp_int   = 1'b0;
        exp_vec   = '0;
        exp_fmt   = '0;
        exp_sr    = '0;
        exp_pc    = '0;
        exp_adr   = '0;
        exp_sp    = '0;
        exp_vbr   = '0;

        set_row(0, 6'b000100, 4'd0, 3'd0, 16'h8000, `EXC_VEC_ILLEGAL, `EXC_FMT_FOUR, 1'b0, 1'b1);
        set_row(1, 6'b100000, 4'd0, 3'd0, 16'h0000, `EXC_VEC_CHK, `EXC_FMT_SIX, 1'b0, 1'b1);
        set_row(2, 6'b010000, 4'd0, 3'd0, 16'h8300, `EXC_VEC_DIVZERO, `EXC_FMT_SIX, 1'b0, 1'b1);
        set_row(3, 6'b001000, 4'd11, 3'd0, 16'h0000, `EXC_VEC_TRAP_BASE + 8'd11,
                `EXC_FMT_FOUR, 1'b0, 1'b1);
        set_row(4, 6'b000010, 4'd0, 3'd0, 16'h0100, `EXC_VEC_PRIV, `EXC_FMT_FOUR, 1'b0, 1'b1);
        set_row(5, 6'b000001, 4'd0, 3'd0, 16'h8000, `EXC_VEC_TRACE, `EXC_FMT_SIX, 1'b0, 1'b1);
        // CHK and TRAP together so TRAP is served by the next row
        set_row(6, 6'b101000, 4'd3, 3'd0, 16'h2000, `EXC_VEC_CHK, `EXC_FMT_SIX, 1'b0, 1'b1);
        set_row(7, 6'b000000, 4'd0, 3'd0, 16'h2000, `EXC_VEC_TRAP_BASE + 8'd3,
                `EXC_FMT_FOUR, 1'b0, 1'b1);
        set_row(8, 6'b000000, 4'd0, 3'd5, 16'h0500, 8'd0, `EXC_FMT_FOUR, 1'b0, 1'b0);
        set_row(9, 6'b000000, 4'd0, 3'd7, 16'h2700, `EXC_VEC_AUTO_BASE + 8'd7,
                `EXC_FMT_FOUR, 1'b1, 1'b1);
        set_row(10, 6'b000000, 4'd0, 3'd4, 16'h0200, `EXC_VEC_AUTO_BASE + 8'd4,
                `EXC_FMT_FOUR, 1'b1, 1'b1);
        rows[10].vbr_we = 1'b1;
        rows[10].vbr    = 32'h0001_0000;
        set_row(11, 6'b000010, 4'd0, 3'd0, 16'h0000, `EXC_VEC_PRIV, `EXC_FMT_FOUR, 1'b0, 1'b1);

        #5 DATA_RDY = 1'b1;
        repeat (3) @(posedge CLK);
        #1 DATA_RDY = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(i);

        asrt_errs = UUT.u_asrt.stall_errs + UUT.u_asrt.load_errs + UUT.u_asrt.reset_errs;
        $display("Entries checked %0d of %0d, value errors %0d, assertion errors %0d",
                 test_count, NUM_ROWS, err_count, asrt_errs);
        if (err_count == 0 && asrt_errs == 0 && test_count == NUM_ROWS)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
exc_pkg.sv
exc_pending.sv
exc_vector.sv
exc_sequencer.sv
exc_handler_top.sv
exc_assertions.sv
exc_checker.sv
tb_exc_handler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exc_handler
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := exc_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
